// ==== design/trace_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the retirement trace block: data widths,
// event and pipeline encodings, reorder queue geometry and emitter sizing
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package trace_pkg;

    typedef logic [31:0] scalar_t;
    typedef logic [1:0] thread_idx_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [7:0] drop_count_t;
    typedef logic [7:0] trace_adr_t;

    typedef enum logic [1:0] {
        PIPE_MULTI,
        PIPE_MEM,
        PIPE_INT
    } pipe_sel_t;

    typedef enum logic [2:0] {
        EVENT_INVALID = 3'd0,
        EVENT_WRITEBACK,
        EVENT_STORE,
        EVENT_INTERRUPT
    } trace_event_type_t;

    // Entry slots are chosen so every path reaches the head at the same delay
    localparam int TRACE_QUEUE_LEN = 7;
    localparam int SLOT_MULTI = 0;
    localparam int SLOT_MEM = 3;
    localparam int SLOT_INT = 4;
    localparam int SLOT_EARLY = 5;

    // Store addresses are reported at cache line granularity
    localparam int LINE_OFFSET_WIDTH = 6;

    localparam int EMIT_FIFO_DEPTH = 4;
    localparam int EMIT_PTR_WIDTH = $clog2(EMIT_FIFO_DEPTH);
    typedef logic [EMIT_PTR_WIDTH-1:0] emit_ptr_t;

    // Register field of the third beat of a store record
    localparam reg_idx_t STORE_DATA_REG = 5'd31;

endpackage

`default_nettype wire

// ==== design/trace_slot.sv ====
////////////////////////////////////////////////////////////////////////////
// One slot of the fixed-position reorder queue
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_slot (
    input wire clk,
    input wire reset,
    input wire load,
    input wire cancel,

    input wire trace_pkg::trace_event_type_t ins_type,
    input wire trace_pkg::scalar_t ins_pc,
    input wire trace_pkg::thread_idx_t ins_thread,
    input wire trace_pkg::reg_idx_t ins_reg,
    input wire trace_pkg::scalar_t ins_value,
    input wire trace_pkg::scalar_t ins_addr,

    input wire trace_pkg::trace_event_type_t next_type,
    input wire trace_pkg::scalar_t next_pc,
    input wire trace_pkg::thread_idx_t next_thread,
    input wire trace_pkg::reg_idx_t next_reg,
    input wire trace_pkg::scalar_t next_value,
    input wire trace_pkg::scalar_t next_addr,

    output trace_pkg::trace_event_type_t slot_type,
    output trace_pkg::scalar_t slot_pc,
    output trace_pkg::thread_idx_t slot_thread,
    output trace_pkg::reg_idx_t slot_reg,
    output trace_pkg::scalar_t slot_value,
    output trace_pkg::scalar_t slot_addr
);

    // The type field alone marks the slot as occupied
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            slot_type <= trace_pkg::EVENT_INVALID;
        else if (cancel)
            slot_type <= trace_pkg::EVENT_INVALID;
        else if (load)
            slot_type <= ins_type;
        else
            slot_type <= next_type;
    end

    // Payload follows the same source as the type, its value is ignored when invalid
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            slot_pc <= ins_pc;
            slot_thread <= ins_thread;
            slot_reg <= ins_reg;
            slot_value <= ins_value;
            slot_addr <= ins_addr;
        end
        else
        begin
            slot_pc <= next_pc;
            slot_thread <= next_thread;
            slot_reg <= next_reg;
            slot_value <= next_value;
            slot_addr <= next_addr;
        end
    end

endmodule

`default_nettype wire

// ==== design/trace_inserter.sv ====
////////////////////////////////////////////////////////////////////////////
// Reorder queue inserter: routes writebacks, stores and interrupts to
// their entry slots and turns a rollback into the slot cancel strobe
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_inserter (
    input wire clk,
    input wire reset,

    input wire wb_en,
    input wire trace_pkg::pipe_sel_t wb_pipe,
    input wire trace_pkg::thread_idx_t wb_thread,
    input wire trace_pkg::reg_idx_t wb_reg,
    input wire trace_pkg::scalar_t wb_pc,
    input wire trace_pkg::scalar_t wb_value,

    input wire store_en,
    input wire trace_pkg::scalar_t store_pc,
    input wire trace_pkg::thread_idx_t store_thread,
    input wire trace_pkg::scalar_t store_addr,
    input wire trace_pkg::scalar_t store_data,

    input wire irq_en,
    input wire trace_pkg::thread_idx_t irq_thread,
    input wire trace_pkg::scalar_t irq_pc,

    input wire cancel_en,

    output logic [trace_pkg::TRACE_QUEUE_LEN-1:0] slot_load,
    output logic [trace_pkg::TRACE_QUEUE_LEN-1:0] slot_cancel,
    output trace_pkg::trace_event_type_t ins_type,
    output trace_pkg::scalar_t ins_pc,
    output trace_pkg::thread_idx_t ins_thread,
    output trace_pkg::reg_idx_t ins_reg,
    output trace_pkg::scalar_t ins_value,
    output trace_pkg::scalar_t ins_addr
);

    // Set when a store or interrupt entered the queue on the previous edge
    logic early_pending;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            early_pending <= 1'b0;
        else
            early_pending <= store_en || irq_en;
    end

    always_comb
    begin
        slot_load = '0;
        slot_cancel = '0;
        ins_type = trace_pkg::EVENT_INVALID;
        ins_pc = '0;
        ins_thread = '0;
        ins_reg = '0;
        ins_value = '0;
        ins_addr = '0;

        if (wb_en)
        begin
            case (wb_pipe)
                trace_pkg::PIPE_INT: slot_load[trace_pkg::SLOT_INT] = 1'b1;
                trace_pkg::PIPE_MEM: slot_load[trace_pkg::SLOT_MEM] = 1'b1;
                default: slot_load[trace_pkg::SLOT_MULTI] = 1'b1;
            endcase
            ins_type = trace_pkg::EVENT_WRITEBACK;
            ins_pc = wb_pc;
            ins_thread = wb_thread;
            ins_reg = wb_reg;
            ins_value = wb_value;
        end

        // The store data rides in the value field for the third beat
        if (store_en)
        begin
            slot_load[trace_pkg::SLOT_EARLY] = 1'b1;
            ins_type = trace_pkg::EVENT_STORE;
            ins_pc = store_pc;
            ins_thread = store_thread;
            ins_reg = '0;
            ins_value = store_data;
            ins_addr = {store_addr[31:trace_pkg::LINE_OFFSET_WIDTH],
                {trace_pkg::LINE_OFFSET_WIDTH{1'b0}}};
        end
        else if (irq_en)
        begin
            slot_load[trace_pkg::SLOT_EARLY] = 1'b1;
            ins_type = trace_pkg::EVENT_INTERRUPT;
            ins_pc = irq_pc;
            ins_thread = irq_thread;
            ins_reg = '0;
            ins_value = '0;
        end

        // A rollback hits the early event just as it moves from slot 5 into slot 4
        slot_cancel[trace_pkg::SLOT_INT] = cancel_en && early_pending;
    end

endmodule

`default_nettype wire

// ==== design/trace_emitter.sv ====
////////////////////////////////////////////////////////////////////////////
// Trace emitter: buffers head events in a small FIFO, sends each as a
// Wishbone classic record of two or three beats, and counts drops
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_emitter (
    input wire clk,
    input wire reset,

    input wire trace_pkg::trace_event_type_t head_type,
    input wire trace_pkg::scalar_t head_pc,
    input wire trace_pkg::thread_idx_t head_thread,
    input wire trace_pkg::reg_idx_t head_reg,
    input wire trace_pkg::scalar_t head_value,
    input wire trace_pkg::scalar_t head_addr,

    output logic trc_cyc,
    output logic trc_stb,
    output logic trc_we,
    output trace_pkg::trace_adr_t trc_adr,
    output trace_pkg::scalar_t trc_dat,
    input wire trc_ack,

    output trace_pkg::drop_count_t drop_count
);

    typedef enum logic [1:0] {
        IDLE,
        BEAT_PC,
        BEAT_INFO,
        BEAT_DATA
    } emit_state_t;

    trace_pkg::trace_event_type_t fifo_type [trace_pkg::EMIT_FIFO_DEPTH];
    trace_pkg::scalar_t fifo_pc [trace_pkg::EMIT_FIFO_DEPTH];
    trace_pkg::thread_idx_t fifo_thread [trace_pkg::EMIT_FIFO_DEPTH];
    trace_pkg::reg_idx_t fifo_reg [trace_pkg::EMIT_FIFO_DEPTH];
    trace_pkg::scalar_t fifo_value [trace_pkg::EMIT_FIFO_DEPTH];
    trace_pkg::scalar_t fifo_addr [trace_pkg::EMIT_FIFO_DEPTH];

    trace_pkg::emit_ptr_t wr_ptr;
    trace_pkg::emit_ptr_t rd_ptr;
    logic [trace_pkg::EMIT_PTR_WIDTH:0] fifo_count;
    logic head_valid;
    logic fifo_full;
    logic push;
    logic pop;
    emit_state_t state;
    emit_state_t state_nxt;

    assign head_valid = head_type != trace_pkg::EVENT_INVALID;
    assign fifo_full = fifo_count == trace_pkg::EMIT_FIFO_DEPTH;
    assign push = head_valid && !fifo_full;

    // The record is complete on the info beat unless a store data beat follows
    assign pop = trc_ack && ((state == BEAT_DATA)
        || (state == BEAT_INFO && fifo_type[rd_ptr] != trace_pkg::EVENT_STORE));

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_type[wr_ptr] <= head_type;
            fifo_pc[wr_ptr] <= head_pc;
            fifo_thread[wr_ptr] <= head_thread;
            fifo_reg[wr_ptr] <= head_reg;
            fifo_value[wr_ptr] <= head_value;
            fifo_addr[wr_ptr] <= head_addr;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
            drop_count <= '0;
            state <= IDLE;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                fifo_count <= fifo_count + 1'b1;
            else if (pop && !push)
                fifo_count <= fifo_count - 1'b1;

            // Saturates so a long stall cannot wrap the count
            if (head_valid && fifo_full && drop_count != '1)
                drop_count <= drop_count + 1'b1;

            state <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE: if (fifo_count != '0) state_nxt = BEAT_PC;
            BEAT_PC: if (trc_ack) state_nxt = BEAT_INFO;
            BEAT_INFO: if (trc_ack) state_nxt = pop ? IDLE : BEAT_DATA;
            BEAT_DATA: if (trc_ack) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // The read entry is stable for the whole record since pushes never land on it
    always_comb
    begin
        trc_cyc = state != IDLE;
        trc_stb = state != IDLE;
        trc_we = 1'b1;
        trc_adr = '0;
        trc_dat = '0;
        case (state)
            BEAT_PC:
            begin
                trc_adr = {2'b00, fifo_type[rd_ptr], fifo_thread[rd_ptr], 1'b0};
                trc_dat = fifo_pc[rd_ptr];
            end
            BEAT_INFO:
            begin
                trc_adr = {2'b00, fifo_reg[rd_ptr], 1'b1};
                if (fifo_type[rd_ptr] == trace_pkg::EVENT_WRITEBACK)
                    trc_dat = fifo_value[rd_ptr];
                else if (fifo_type[rd_ptr] == trace_pkg::EVENT_STORE)
                    trc_dat = fifo_addr[rd_ptr];
            end
            BEAT_DATA:
            begin
                trc_adr = {2'b00, trace_pkg::STORE_DATA_REG, 1'b1};
                trc_dat = fifo_value[rd_ptr];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/trace_reorder_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Retirement trace top level: inserter, reorder queue slots and the
// Wishbone trace emitter
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_reorder_top (
    input wire clk,
    input wire reset,

    input wire wb_en,
    input wire trace_pkg::pipe_sel_t wb_pipe,
    input wire trace_pkg::thread_idx_t wb_thread,
    input wire trace_pkg::reg_idx_t wb_reg,
    input wire trace_pkg::scalar_t wb_pc,
    input wire trace_pkg::scalar_t wb_value,

    input wire store_en,
    input wire trace_pkg::scalar_t store_pc,
    input wire trace_pkg::thread_idx_t store_thread,
    input wire trace_pkg::scalar_t store_addr,
    input wire trace_pkg::scalar_t store_data,

    input wire irq_en,
    input wire trace_pkg::thread_idx_t irq_thread,
    input wire trace_pkg::scalar_t irq_pc,

    input wire cancel_en,

    output logic trc_cyc,
    output logic trc_stb,
    output logic trc_we,
    output trace_pkg::trace_adr_t trc_adr,
    output trace_pkg::scalar_t trc_dat,
    input wire trc_ack,

    output trace_pkg::drop_count_t drop_count
);

    logic [trace_pkg::TRACE_QUEUE_LEN-1:0] slot_load;
    logic [trace_pkg::TRACE_QUEUE_LEN-1:0] slot_cancel;
    trace_pkg::trace_event_type_t ins_type;
    trace_pkg::scalar_t ins_pc;
    trace_pkg::thread_idx_t ins_thread;
    trace_pkg::reg_idx_t ins_reg;
    trace_pkg::scalar_t ins_value;
    trace_pkg::scalar_t ins_addr;

    // Entry TRACE_QUEUE_LEN is the constant invalid event feeding the top slot
    trace_pkg::trace_event_type_t q_type [trace_pkg::TRACE_QUEUE_LEN+1];
    trace_pkg::scalar_t q_pc [trace_pkg::TRACE_QUEUE_LEN+1];
    trace_pkg::thread_idx_t q_thread [trace_pkg::TRACE_QUEUE_LEN+1];
    trace_pkg::reg_idx_t q_reg [trace_pkg::TRACE_QUEUE_LEN+1];
    trace_pkg::scalar_t q_value [trace_pkg::TRACE_QUEUE_LEN+1];
    trace_pkg::scalar_t q_addr [trace_pkg::TRACE_QUEUE_LEN+1];

    assign q_type[trace_pkg::TRACE_QUEUE_LEN] = trace_pkg::EVENT_INVALID;
    assign q_pc[trace_pkg::TRACE_QUEUE_LEN] = '0;
    assign q_thread[trace_pkg::TRACE_QUEUE_LEN] = '0;
    assign q_reg[trace_pkg::TRACE_QUEUE_LEN] = '0;
    assign q_value[trace_pkg::TRACE_QUEUE_LEN] = '0;
    assign q_addr[trace_pkg::TRACE_QUEUE_LEN] = '0;

    trace_inserter inserter_i (
        .clk(clk), .reset(reset),
        .wb_en(wb_en), .wb_pipe(wb_pipe), .wb_thread(wb_thread),
        .wb_reg(wb_reg), .wb_pc(wb_pc), .wb_value(wb_value),
        .store_en(store_en), .store_pc(store_pc), .store_thread(store_thread),
        .store_addr(store_addr), .store_data(store_data),
        .irq_en(irq_en), .irq_thread(irq_thread), .irq_pc(irq_pc),
        .cancel_en(cancel_en),
        .slot_load(slot_load), .slot_cancel(slot_cancel),
        .ins_type(ins_type), .ins_pc(ins_pc), .ins_thread(ins_thread),
        .ins_reg(ins_reg), .ins_value(ins_value), .ins_addr(ins_addr)
    );

    for (genvar i = 0; i < trace_pkg::TRACE_QUEUE_LEN; i++)
    begin : slot_gen
        trace_slot slot_i (
            .clk(clk), .reset(reset),
            .load(slot_load[i]), .cancel(slot_cancel[i]),
            .ins_type(ins_type), .ins_pc(ins_pc), .ins_thread(ins_thread),
            .ins_reg(ins_reg), .ins_value(ins_value), .ins_addr(ins_addr),
            .next_type(q_type[i+1]), .next_pc(q_pc[i+1]), .next_thread(q_thread[i+1]),
            .next_reg(q_reg[i+1]), .next_value(q_value[i+1]), .next_addr(q_addr[i+1]),
            .slot_type(q_type[i]), .slot_pc(q_pc[i]), .slot_thread(q_thread[i]),
            .slot_reg(q_reg[i]), .slot_value(q_value[i]), .slot_addr(q_addr[i])
        );
    end

    trace_emitter emitter_i (
        .clk(clk), .reset(reset),
        .head_type(q_type[0]), .head_pc(q_pc[0]), .head_thread(q_thread[0]),
        .head_reg(q_reg[0]), .head_value(q_value[0]), .head_addr(q_addr[0]),
        .trc_cyc(trc_cyc), .trc_stb(trc_stb), .trc_we(trc_we),
        .trc_adr(trc_adr), .trc_dat(trc_dat), .trc_ack(trc_ack),
        .drop_count(drop_count)
    );

endmodule

`default_nettype wire

// ==== sim/trace_reorder_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the retirement trace block: replays the case file, models
// a Wishbone sink with fixed or random ack delays, checks every beat
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trace_reorder_tb;

    logic clk;
    logic reset;
    logic wb_en;
    trace_pkg::pipe_sel_t wb_pipe;
    trace_pkg::thread_idx_t wb_thread;
    trace_pkg::reg_idx_t wb_reg;
    trace_pkg::scalar_t wb_pc;
    trace_pkg::scalar_t wb_value;
    logic store_en;
    trace_pkg::scalar_t store_pc;
    trace_pkg::thread_idx_t store_thread;
    trace_pkg::scalar_t store_addr;
    trace_pkg::scalar_t store_data;
    logic irq_en;
    trace_pkg::thread_idx_t irq_thread;
    trace_pkg::scalar_t irq_pc;
    logic cancel_en;
    logic trc_cyc;
    logic trc_stb;
    logic trc_we;
    trace_pkg::trace_adr_t trc_adr;
    trace_pkg::scalar_t trc_dat;
    logic trc_ack;
    trace_pkg::drop_count_t drop_count;

    // Replay program and the expected beat sequence from the case file
    byte ops[$];
    logic [31:0] arg_a[$];
    logic [31:0] arg_b[$];
    logic [31:0] arg_c[$];
    logic [31:0] arg_d[$];
    logic [31:0] arg_e[$];
    logic [7:0] exp_adr[$];
    logic [31:0] exp_dat[$];
    logic [31:0] exp_drops;
    int stim_cycles;
    int cycle_limit;
    int cycle_count;
    logic limit_ready;

    // Sink state
    logic random_mode;
    int fixed_delay;
    int wait_cnt;
    logic in_beat;
    logic [31:0] lcg_state;

    trace_reorder_top dut_i (
        .clk(clk), .reset(reset),
        .wb_en(wb_en), .wb_pipe(wb_pipe), .wb_thread(wb_thread),
        .wb_reg(wb_reg), .wb_pc(wb_pc), .wb_value(wb_value),
        .store_en(store_en), .store_pc(store_pc), .store_thread(store_thread),
        .store_addr(store_addr), .store_data(store_data),
        .irq_en(irq_en), .irq_thread(irq_thread), .irq_pc(irq_pc),
        .cancel_en(cancel_en),
        .trc_cyc(trc_cyc), .trc_stb(trc_stb), .trc_we(trc_we),
        .trc_adr(trc_adr), .trc_dat(trc_dat), .trc_ack(trc_ack),
        .drop_count(drop_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic load_cases();
        int fd;
        int r;
        string line;
        string tag;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("sim/trace_cases.txt", "r");
        if (fd == 0)
            report_failure("Could not open the case file sim/trace_cases.txt");
        stim_cycles = 0;
        while (!$feof(fd))
        begin
            r = $fgets(line, fd);
            if (r == 0 || line.len() < 1)
                continue;
            if (line.getc(0) == "#" || line.getc(0) == "\n")
                continue;
            r = $sscanf(line, "%s %h %h %h %h %h", tag, a, b, c, d, e);
            if (tag == "E")
            begin
                exp_adr.push_back(a[7:0]);
                exp_dat.push_back(b);
            end
            else if (tag == "D")
                exp_drops = a;
            else
            begin
                ops.push_back(tag.getc(0));
                arg_a.push_back(a);
                arg_b.push_back(b);
                arg_c.push_back(c);
                arg_d.push_back(d);
                arg_e.push_back(e);
                if (tag == "N")
                    stim_cycles += int'(a);
                else if (tag == "W" || tag == "T" || tag == "Q" || tag == "C")
                    stim_cycles += 1;
            end
        end
        $fclose(fd);
    endtask

    task automatic clear_inputs();
        wb_en = 1'b0;
        store_en = 1'b0;
        irq_en = 1'b0;
        cancel_en = 1'b0;
    endtask

    task automatic drive_event(input byte op, input logic [31:0] a, input logic [31:0] b,
        input logic [31:0] c, input logic [31:0] d, input logic [31:0] e);
        clear_inputs();
        case (op)
            "W":
            begin
                wb_en = 1'b1;
                wb_pipe = trace_pkg::pipe_sel_t'(a[1:0]);
                wb_thread = b[1:0];
                wb_reg = c[4:0];
                wb_pc = d;
                wb_value = e;
            end
            "T":
            begin
                store_en = 1'b1;
                store_thread = a[1:0];
                store_pc = b;
                store_addr = c;
                store_data = d;
            end
            "Q":
            begin
                irq_en = 1'b1;
                irq_thread = a[1:0];
                irq_pc = b;
            end
            "C": cancel_en = 1'b1;
            default: ;
        endcase
    endtask

    // Each beat waits its delay, then ack is held for one cycle
    task automatic sink_step();
        if (trc_ack)
        begin
            trc_ack = 1'b0;
            in_beat = 1'b0;
        end
        else if (trc_cyc)
        begin
            if (!in_beat)
            begin
                in_beat = 1'b1;
                wait_cnt = random_mode ? next_rand() % 4 : fixed_delay;
            end
            if (wait_cnt == 0)
                trc_ack = 1'b1;
            else
                wait_cnt--;
        end
    endtask

    // Sampled mid-cycle, where bus outputs and ack are settled
    task automatic monitor_bus();
        if (!trc_cyc)
            check_value("trc_stb", {31'd0, trc_stb}, 32'd0);
        else if (exp_adr.size() == 0)
            report_failure("Bus cycle started with no record left to expect");
        else
        begin
            // Address and data hold the expected beat on every cycle until it is acked
            check_value("trc_stb", {31'd0, trc_stb}, 32'd1);
            check_value("trc_we", {31'd0, trc_we}, 32'd1);
            check_value("trc_adr", {24'd0, trc_adr}, {24'd0, exp_adr[0]});
            check_value("trc_dat", trc_dat, exp_dat[0]);
            if (trc_ack)
            begin
                void'(exp_adr.pop_front());
                void'(exp_dat.pop_front());
            end
        end
    endtask

    task automatic step_cycle(input byte op, input logic [31:0] a, input logic [31:0] b,
        input logic [31:0] c, input logic [31:0] d, input logic [31:0] e);
        @(posedge clk);
        #10;
        drive_event(op, a, b, c, d, e);
        sink_step();
        @(negedge clk);
        monitor_bus();
    endtask

    initial
    begin
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count <= cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the trace records did not finish within %0d cycles", cycle_limit);
        $display("Test failed");
        $fatal(1);
    end

    initial
    begin
        reset = 1'b1;
        clear_inputs();
        wb_pipe = trace_pkg::PIPE_MULTI;
        wb_thread = '0;
        wb_reg = '0;
        wb_pc = '0;
        wb_value = '0;
        store_pc = '0;
        store_thread = '0;
        store_addr = '0;
        store_data = '0;
        irq_thread = '0;
        irq_pc = '0;
        trc_ack = 1'b0;
        random_mode = 1'b0;
        fixed_delay = 0;
        wait_cnt = 0;
        in_beat = 1'b0;
        lcg_state = 32'd54803;
        exp_drops = '0;
        limit_ready = 1'b0;

        load_cases();
        cycle_limit = (stim_cycles + 40) * 8;
        limit_ready = 1'b1;

        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        check_value("trc_cyc", {31'd0, trc_cyc}, 32'd0);
        check_value("trc_stb", {31'd0, trc_stb}, 32'd0);
        check_value("drop_count", {24'd0, drop_count}, 32'd0);

        for (int i = 0; i < ops.size(); i++)
        begin
            if (ops[i] == "S")
            begin
                random_mode = 1'b0;
                fixed_delay = int'(arg_a[i]);
            end
            else if (ops[i] == "R")
                random_mode = 1'b1;
            else if (ops[i] == "N")
                repeat (int'(arg_a[i])) step_cycle("N", 0, 0, 0, 0, 0);
            else
                step_cycle(ops[i], arg_a[i], arg_b[i], arg_c[i], arg_d[i], arg_e[i]);
        end

        while (exp_adr.size() != 0)
            step_cycle("N", 0, 0, 0, 0, 0);
        repeat (5) step_cycle("N", 0, 0, 0, 0, 0);

        check_value("drop_count", {24'd0, drop_count}, exp_drops);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/trace_cases.txt ====
# Tags: S delay | R | N cycles | W pipe thread reg pc value | T thread pc addr data
#       Q thread pc | C | E adr dat (expected beat) | D drops.  All numbers hex
S 0
N 3
W 1 1 05 00000104 0000aaaa
W 2 2 06 0000010c 0000bbbb
W 0 0 04 00000100 00001111
E 08 00000100
E 09 00001111
E 0a 00000104
E 0b 0000aaaa
E 0c 0000010c
E 0d 0000bbbb
N 12
# Store, interrupt, cancelled store, cancelled interrupt
S 1
T 3 00000200 12345678 deadbeef
N 1
Q 1 00000300
T 0 00000400 00000fff 55555555
C
N 1
W 1 2 07 00000408 0000dddd
Q 2 00000500
C
N 1
W 2 3 08 00000504 0000eeee
E 16 00000200
E 01 12345640
E 3f deadbeef
E 1a 00000300
E 01 00000000
E 0c 00000408
E 0f 0000dddd
E 0e 00000504
E 11 0000eeee
N 20
# Random ack delays
R
W 0 0 01 00001000 a0000001
N 7
W 1 1 02 00001004 a0000002
N 7
W 2 2 03 00001008 a0000003
N 7
W 0 3 04 0000100c a0000004
N 7
W 1 0 05 00001010 a0000005
N 7
W 2 1 06 00001014 a0000006
E 08 00001000
E 03 a0000001
E 0a 00001004
E 05 a0000002
E 0c 00001008
E 07 a0000003
E 0e 0000100c
E 09 a0000004
E 08 00001010
E 0b a0000005
E 0a 00001014
E 0d a0000006
N 40
# Long stall, the last two events are dropped
S 14
W 0 0 0a 00002000 b0000000
W 0 1 0b 00002004 b0000001
W 0 2 0c 00002008 b0000002
W 0 3 0d 0000200c b0000003
W 0 0 0e 00002010 b0000004
W 0 1 0f 00002014 b0000005
E 08 00002000
E 15 b0000000
E 0a 00002004
E 17 b0000001
E 0c 00002008
E 19 b0000002
E 0e 0000200c
E 1b b0000003
D 2

// ==== src.f ====
design/trace_pkg.sv
design/trace_slot.sv
design/trace_inserter.sv
design/trace_emitter.sv
design/trace_reorder_top.sv
sim/trace_reorder_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = trace_reorder_tb
FILELIST = src.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
